/* project.f */
+incdir+verilog
verilog/axi_read_pkg.sv
verilog/read_cmd_decode.sv
verilog/read_addr_issue.sv
verilog/read_return_buffer.sv
verilog/axi_read_master.sv
test/tb_read_checker.sv
test/tb_axi_read_master.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the AXI read master testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_axi_read_master -f project.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* test/tb_axi_read_master.sv */
//////////////////////////////////////////////////
// Testbench for the AXI read master
// Memory model answers each beat with its byte address
// Commands run one at a time and each waits for ctrl_done
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module tb_axi_read_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CMDS       = 12;
  localparam int MAX_SIZE       = 300;
  localparam int WORD_BYTES     = `AXI_DATA_WIDTH / 8;
  localparam int MAX_WORDS      = (MAX_SIZE + WORD_BYTES - 1) / WORD_BYTES;
  // Room for slow slave and long stream stalls on every command
  localparam int TIMEOUT_CYCLES = NUM_CMDS * (MAX_WORDS * 8 + 50);

  logic                        aclk   = 1'b0;
  logic                        areset = 1'b1;
  logic                        ctrl_start;
  logic                        ctrl_done;
  logic [`AXI_ADDR_WIDTH-1:0]  ctrl_addr_offset;
  logic [`XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes;
  logic                        m_axi_arvalid;
  logic                        m_axi_arready = 1'b0;
  logic [`AXI_ADDR_WIDTH-1:0]  m_axi_araddr;
  logic [7:0]                  m_axi_arlen;
  logic                        m_axi_rvalid  = 1'b0;
  logic                        m_axi_rready;
  logic [`AXI_DATA_WIDTH-1:0]  m_axi_rdata   = '0;
  logic                        m_axi_rlast   = 1'b0;
  logic                        m_axis_tvalid;
  logic                        m_axis_tready = 1'b0;
  logic [`AXI_DATA_WIDTH-1:0]  m_axis_tdata;
  logic                        m_axis_tlast;

  int error_count;
  int check_count;
  int cmds_finished;
  int cycle_count;

  logic [31:0]                 lfsr_state = 32'hecd0d62a;
  logic [`AXI_ADDR_WIDTH-1:0]  cmd_addr [NUM_CMDS];
  logic [`XFER_SIZE_WIDTH-1:0] cmd_size [NUM_CMDS];

  // Memory model queue of accepted bursts in order
  logic [`AXI_ADDR_WIDTH-1:0] slave_addr_q[$];
  logic [7:0]                 slave_len_q[$];
  logic [`AXI_ADDR_WIDTH-1:0] r_addr      = '0;
  int                         r_left      = 0;
  int                         stall_left  = 0;
  logic                       slave_reset = 1'b1;

  axi_read_master i_dut (.*);

  tb_read_checker i_checker (.*);

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////
  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  initial begin
    forever #50 aclk = ~aclk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the commands did not all finish", cycle_count);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Memory slave model driven on the falling edge
  //////////////////////////////////////////////////
  // Reset as the DUT saw it at the last rising edge
  always @(posedge aclk) begin
    slave_reset <= areset;
  end

  always @(negedge aclk) begin
    if (slave_reset) begin
      m_axi_arready = 1'b0;
      m_axi_rvalid  = 1'b0;
      m_axi_rlast   = 1'b0;
      m_axis_tready = 1'b0;
      r_left        = 0;
      stall_left    = 0;
    end else begin
      // Beat shown last cycle was taken since rready is tied high
      if (m_axi_rvalid) begin
        r_addr = r_addr + `AXI_ADDR_WIDTH'(WORD_BYTES);
        r_left--;
      end
      // Popped before this cycle's push so data never beats its address
      if (r_left == 0 && slave_addr_q.size() != 0) begin
        r_addr = slave_addr_q.pop_front();
        r_left = int'(slave_len_q.pop_front()) + 1;
      end
      m_axi_rvalid = 1'b0;
      if (r_left > 0) begin
        m_axi_rvalid = (take_bits(2) != 0);
      end
      m_axi_rdata = r_addr;
      m_axi_rlast = (r_left == 1);

      // Handshake lands on the next rising edge
      m_axi_arready = (take_bits(2) != 0);
      if (m_axi_arvalid && m_axi_arready) begin
        slave_addr_q.push_back(m_axi_araddr);
        slave_len_q.push_back(m_axi_arlen);
      end

      // Mostly ready with now and then a long stall
      if (stall_left > 0) begin
        m_axis_tready = 1'b0;
        stall_left--;
      end else if (take_bits(5) == 0) begin
        m_axis_tready = 1'b0;
        stall_left    = int'(take_bits(6));
      end else begin
        m_axis_tready = (take_bits(2) != 0);
      end
    end
  end

  //////////////////////////////////////////////////
  // Command sequence
  //////////////////////////////////////////////////
  initial begin
    ctrl_start              = 1'b0;
    ctrl_addr_offset        = '0;
    ctrl_xfer_size_in_bytes = '0;
    for (int c = 0; c < NUM_CMDS; c++) begin
      cmd_addr[c] = `AXI_ADDR_WIDTH'(take_bits(20));
      cmd_size[c] = `XFER_SIZE_WIDTH'(take_bits(9) % MAX_SIZE + 1);
    end

    repeat (3) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;

    for (int c = 0; c < NUM_CMDS; c++) begin
      @(negedge aclk);
      ctrl_addr_offset        = cmd_addr[c];
      ctrl_xfer_size_in_bytes = cmd_size[c];
      ctrl_start              = 1'b1;
      @(negedge aclk);
      ctrl_start = 1'b0;
      while (ctrl_done !== 1'b1) begin
        @(negedge aclk);
      end
    end

    // Done may come with data still buffered
    while (cmds_finished < NUM_CMDS) begin
      @(negedge aclk);
    end
    repeat (2) @(negedge aclk);

    $display("Summary: %0d of %0d commands, %0d checks, %0d errors",
             cmds_finished, NUM_CMDS, check_count, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* test/tb_read_checker.sv */
//////////////////////////////////////////////////
// Scoreboard for the AXI read master
// Expects one command in the DUT at a time
// Expected values follow the burst split rules only
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module tb_read_checker (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        ctrl_start,
  input  logic                        ctrl_done,
  input  logic [`AXI_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  logic [`XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  input  logic                        m_axi_arvalid,
  input  logic                        m_axi_arready,
  input  logic [`AXI_ADDR_WIDTH-1:0]  m_axi_araddr,
  input  logic [7:0]                  m_axi_arlen,
  input  logic                        m_axi_rvalid,
  input  logic                        m_axi_rready,
  input  logic                        m_axi_rlast,
  input  logic                        m_axis_tvalid,
  input  logic                        m_axis_tready,
  input  logic [`AXI_DATA_WIDTH-1:0]  m_axis_tdata,
  input  logic                        m_axis_tlast,
  output int                          error_count,
  output int                          check_count,
  output int                          cmds_finished
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORD_BYTES = `AXI_DATA_WIDTH / 8;
  localparam int BEATS      = `MAX_BURST_BEATS;
  localparam int BURST_SPAN = WORD_BYTES * BEATS;

  int   errors      = 0;
  int   checks      = 0;
  int   finished    = 0;
  int   cmd_errors  = 0;
  int   outstanding = 0;
  int   rlast_count = 0;
  // Edges since the last ctrl_start, saturates
  int   since_start = 1000;
  logic after_reset = 1'b0;
  logic done_due    = 1'b0;
  logic done_next;

  // Expected address bursts, stream beats and per-command info
  logic [`AXI_ADDR_WIDTH-1:0] ar_addr_q[$];
  logic [7:0]                 ar_len_q[$];
  logic [`AXI_DATA_WIDTH-1:0] beat_data_q[$];
  logic                       beat_last_q[$];
  logic                       beat_end_q[$];
  int                         rlast_goal_q[$];
  logic [`AXI_ADDR_WIDTH-1:0] info_base_q[$];
  int                         info_words_q[$];

  // Values popped off the queues
  logic [`AXI_ADDR_WIDTH-1:0] exp_addr;
  logic [7:0]                 exp_len;
  logic [`AXI_DATA_WIDTH-1:0] exp_data;
  logic                       exp_last;
  logic                       exp_end;

  assign error_count   = errors;
  assign check_count   = checks;
  assign cmds_finished = finished;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      cmd_errors++;
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_problem(input string text);
    errors++;
    cmd_errors++;
    $display("Error at %0d ns: %s", $time, text);
  endtask

  //////////////////////////////////////////////////
  // Reference model of one command
  //////////////////////////////////////////////////
  task automatic predict_command(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int size);
    logic [`AXI_ADDR_WIDTH-1:0] base;
    int                         words;
    int                         bursts;
    // Aligned down to a full burst
    base   = addr & ~`AXI_ADDR_WIDTH'(BURST_SPAN - 1);
    words  = (size + WORD_BYTES - 1) / WORD_BYTES;
    bursts = (words + BEATS - 1) / BEATS;
    for (int k = 0; k < bursts; k++) begin
      ar_addr_q.push_back(base + `AXI_ADDR_WIDTH'(BURST_SPAN * k));
      if (k == bursts - 1) begin
        ar_len_q.push_back(8'(words - BEATS * (bursts - 1) - 1));
      end else begin
        ar_len_q.push_back(8'(BEATS - 1));
      end
    end
    // Memory returns the byte address as data
    for (int i = 0; i < words; i++) begin
      beat_data_q.push_back(base + `AXI_ADDR_WIDTH'(WORD_BYTES * i));
      beat_last_q.push_back(((i + 1) % BEATS == 0) || (i == words - 1));
      beat_end_q.push_back(i == words - 1);
    end
    rlast_goal_q.push_back(bursts);
    info_base_q.push_back(base);
    info_words_q.push_back(words);
  endtask

  // Final stream beat of a command closes its report
  task automatic close_command();
    logic [`AXI_ADDR_WIDTH-1:0] base;
    int                         words;
    base  = info_base_q.pop_front();
    words = info_words_q.pop_front();
    finished++;
    $display("Command %0d finished at %0d ns: base %h, %0d words, %0d errors",
             finished, $time, base, words, cmd_errors);
    cmd_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // Port monitor, values taken before the edge updates them
  //////////////////////////////////////////////////
  always @(posedge aclk) begin
    done_next = 1'b0;
    // Outputs set by a reset edge must be low
    if (after_reset) begin
      compare_value("m_axi_arvalid", 32'h0, 32'(m_axi_arvalid));
      compare_value("m_axis_tvalid", 32'h0, 32'(m_axis_tvalid));
      compare_value("ctrl_done", 32'h0, 32'(ctrl_done));
    end
    after_reset = areset;
    if (!areset) begin
      compare_value("ctrl_done", 32'(done_due), 32'(ctrl_done));
      if (since_start < 1000) begin
        since_start++;
      end
      if (ctrl_start) begin
        since_start = 0;
        predict_command(ctrl_addr_offset, int'(ctrl_xfer_size_in_bytes));
      end
      // Decode takes two cycles, issue one more
      if (m_axi_arvalid && since_start <= 3) begin
        report_problem($sformatf("m_axi_arvalid high %0d edges after ctrl_start",
                                 since_start));
      end

      // Address channel
      if (m_axi_arvalid && m_axi_arready) begin
        if (ar_addr_q.size() == 0) begin
          report_problem("address handshake with no burst expected");
        end else begin
          exp_addr = ar_addr_q.pop_front();
          exp_len  = ar_len_q.pop_front();
          compare_value("m_axi_araddr", exp_addr, m_axi_araddr);
          compare_value("m_axi_arlen", 32'(exp_len), 32'(m_axi_arlen));
        end
        outstanding++;
      end

      // Read channel, done is due one edge after the final rlast
      if (m_axi_rvalid) begin
        compare_value("m_axi_rready", 32'h1, 32'(m_axi_rready));
      end
      if (m_axi_rvalid && m_axi_rlast) begin
        rlast_count++;
        if (rlast_goal_q.size() == 0) begin
          report_problem("rlast seen with no command pending");
        end else if (rlast_count == rlast_goal_q[0]) begin
          rlast_goal_q.delete(0);
          rlast_count = 0;
          done_next   = 1'b1;
        end
      end

      // Output stream
      if (m_axis_tvalid && m_axis_tready) begin
        if (beat_data_q.size() == 0) begin
          report_problem("stream beat with no data expected");
        end else begin
          exp_data = beat_data_q.pop_front();
          exp_last = beat_last_q.pop_front();
          exp_end  = beat_end_q.pop_front();
          compare_value("m_axis_tdata", exp_data, m_axis_tdata);
          compare_value("m_axis_tlast", 32'(exp_last), 32'(m_axis_tlast));
          if (exp_end) begin
            close_command();
          end
        end
        if (m_axis_tlast) begin
          outstanding--;
        end
      end

      if (outstanding > `MAX_OUTSTANDING) begin
        report_problem($sformatf("%0d bursts outstanding, above the limit", outstanding));
      end
    end
    done_due = done_next;
  end

endmodule

/* verilog/axi_read_config.svh */
//////////////////////////////////////////////////
// Size settings for the AXI read master
// MAX_BURST_BEATS must be a power of two, 256 at most
// One burst must not cross 4096 bytes
// MAX_OUTSTANDING times the burst sets the buffer depth
//////////////////////////////////////////////////

`ifndef AXI_READ_CONFIG_SVH
`define AXI_READ_CONFIG_SVH

// Bus address width in bits
`define AXI_ADDR_WIDTH 32

// Data word width in bits, 4 bytes per beat
`define AXI_DATA_WIDTH 32

// Width of the byte count on the control side
`define XFER_SIZE_WIDTH 16

// Beats in one full burst
// Beats times bytes per word stays at or below 4096
`define MAX_BURST_BEATS 16

// Bursts issued but not yet drained from the stream
`define MAX_OUTSTANDING 4

`endif

/* verilog/axi_read_master.sv */
//////////////////////////////////////////////////
// AXI read master with stream output
// New command only after ctrl_done, byte count above zero
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module axi_read_master (
  input  logic                        aclk,
  input  logic                        areset,
  // Control
  input  logic                        ctrl_start,
  output logic                        ctrl_done,
  input  logic [`AXI_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  logic [`XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  // Read address channel
  output logic                        m_axi_arvalid,
  input  logic                        m_axi_arready,
  output logic [`AXI_ADDR_WIDTH-1:0]  m_axi_araddr,
  output logic [7:0]                  m_axi_arlen,
  // Read data channel
  input  logic                        m_axi_rvalid,
  output logic                        m_axi_rready,
  input  logic [`AXI_DATA_WIDTH-1:0]  m_axi_rdata,
  input  logic                        m_axi_rlast,
  // Output stream
  output logic                        m_axis_tvalid,
  input  logic                        m_axis_tready,
  output logic [`AXI_DATA_WIDTH-1:0]  m_axis_tdata,
  output logic                        m_axis_tlast
);

  import axi_read_pkg::*;

  logic                       cmd_load;
  logic [`AXI_ADDR_WIDTH-1:0] cmd_addr;
  rd_len_u                    cmd_len;
  logic                       burst_retired;

  // Buffer always has room for the bursts in flight
  assign m_axi_rready = 1'b1;

  read_cmd_decode i_decode (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .cmd_load                (cmd_load),
    .cmd_addr                (cmd_addr),
    .cmd_len                 (cmd_len)
  );

  read_addr_issue i_issue (
    .aclk          (aclk),
    .areset        (areset),
    .cmd_load      (cmd_load),
    .cmd_addr      (cmd_addr),
    .cmd_len       (cmd_len),
    .burst_retired (burst_retired),
    .m_axi_arvalid (m_axi_arvalid),
    .m_axi_arready (m_axi_arready),
    .m_axi_araddr  (m_axi_araddr),
    .m_axi_arlen   (m_axi_arlen)
  );

  read_return_buffer i_return (
    .aclk          (aclk),
    .areset        (areset),
    .cmd_load      (cmd_load),
    .cmd_len       (cmd_len),
    .m_axi_rvalid  (m_axi_rvalid),
    .m_axi_rdata   (m_axi_rdata),
    .m_axi_rlast   (m_axi_rlast),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .burst_retired (burst_retired),
    .ctrl_done     (ctrl_done)
  );

endmodule

/* verilog/axi_read_pkg.sv */
//////////////////////////////////////////////////
// Derived constants and the shared length type
// All values follow from the config header
//////////////////////////////////////////////////

`include "axi_read_config.svh"

package axi_read_pkg;

  //////////////////////////////////////////////////
  // Derived sizes
  //////////////////////////////////////////////////
  localparam int DW_BYTES          = `AXI_DATA_WIDTH / 8;
  localparam int LOG_DW_BYTES      = $clog2(DW_BYTES);
  localparam int LOG_BURST         = $clog2(`MAX_BURST_BEATS);
  localparam int BURST_BYTES       = DW_BYTES * `MAX_BURST_BEATS;
  // Word count minus one, after dropping the byte offset bits
  localparam int LEN_WIDTH         = `XFER_SIZE_WIDTH - LOG_DW_BYTES;
  // Upper part of the word count selects the burst
  localparam int XACT_WIDTH        = LEN_WIDTH - LOG_BURST;
  // Vacancy counter has to reach MAX_OUTSTANDING itself
  localparam int OUTSTANDING_WIDTH = $clog2(`MAX_OUTSTANDING + 1);
  // Room for every outstanding burst, power of two
  localparam int FIFO_DEPTH        = 2 ** $clog2(`MAX_BURST_BEATS * `MAX_OUTSTANDING);
  localparam int FIFO_AWIDTH       = $clog2(FIFO_DEPTH);

  //////////////////////////////////////////////////
  // Length word, flat or split into bursts
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [XACT_WIDTH-1:0] bursts;    // Full bursts beyond the first
    logic [LOG_BURST-1:0]  last_len;  // Final burst beats minus one
  } rd_len_fields_s;

  typedef union packed {
    logic [LEN_WIDTH-1:0] words;      // Total words minus one
    rd_len_fields_s       fields;
  } rd_len_u;

endpackage

/* verilog/read_addr_issue.sv */
//////////////////////////////////////////////////
// Read address channel driver
// Full bursts first, the final burst may be short
// At most MAX_OUTSTANDING bursts held by the stream
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module read_addr_issue (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       cmd_load,
  input  logic [`AXI_ADDR_WIDTH-1:0] cmd_addr,
  input  axi_read_pkg::rd_len_u      cmd_len,
  input  logic                       burst_retired,
  output logic                       m_axi_arvalid,
  input  logic                       m_axi_arready,
  output logic [`AXI_ADDR_WIDTH-1:0] m_axi_araddr,
  output logic [7:0]                 m_axi_arlen
);

  import axi_read_pkg::*;

  localparam logic [7:0] FULL_ARLEN = 8'(`MAX_BURST_BEATS - 1);
  localparam logic [OUTSTANDING_WIDTH-1:0] VACANCY_INIT =
    OUTSTANDING_WIDTH'(`MAX_OUTSTANDING);

  logic                         ar_idle;
  logic                         arxfer;
  logic                         ar_final;
  logic                         ar_done;
  logic                         stall_ar;
  logic [XACT_WIDTH-1:0]        ar_to_go;
  logic [OUTSTANDING_WIDTH-1:0] vacancy;

  assign arxfer   = m_axi_arvalid & m_axi_arready;
  assign ar_final = (ar_to_go == '0);
  assign ar_done  = ar_final & arxfer;
  assign stall_ar = (vacancy == '0);

  // Final burst takes the short length
  assign m_axi_arlen = ar_final ? 8'(cmd_len.fields.last_len) : FULL_ARLEN;

  //////////////////////////////////////////////////
  // Control state
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (cmd_load) begin
      ar_idle <= 1'b0;
    end else if (ar_done) begin
      ar_idle <= 1'b1;
    end
  end

  // Valid rises one cycle after issue is allowed, drops after a handshake
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_arvalid <= 1'b0;
    end else if (!ar_idle && !stall_ar && !m_axi_arvalid) begin
      m_axi_arvalid <= 1'b1;
    end else if (m_axi_arready) begin
      m_axi_arvalid <= 1'b0;
    end
  end

  // Bursts still to issue, after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_to_go <= '0;
    end else if (cmd_load) begin
      ar_to_go <= cmd_len.fields.bursts;
    end else if (arxfer && !ar_final) begin
      ar_to_go <= ar_to_go - 1'b1;
    end
  end

  // Free slots, down on handshake, up on retire
  always_ff @(posedge aclk) begin
    if (areset) begin
      vacancy <= VACANCY_INIT;
    end else begin
      case ({arxfer, burst_retired})
        2'b10:   vacancy <= vacancy - 1'b1;
        2'b01:   vacancy <= vacancy + 1'b1;
        default: vacancy <= vacancy;
      endcase
    end
  end

  // Address walks one burst per handshake
  always_ff @(posedge aclk) begin
    if (cmd_load) begin
      m_axi_araddr <= cmd_addr;
    end else if (arxfer) begin
      m_axi_araddr <= m_axi_araddr + `AXI_ADDR_WIDTH'(BURST_BYTES);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////
  a_ar_stable: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen)
  );

  // Retires only come for bursts that were issued
  a_vacancy_max: assert property (
    @(posedge aclk) disable iff (areset)
    vacancy <= VACANCY_INIT
  );

endmodule

/* verilog/read_cmd_decode.sv */
//////////////////////////////////////////////////
// Command capture for the read master
// Byte count of zero is not supported
// Start address is aligned down to a burst boundary
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module read_cmd_decode (
  input  logic                        aclk,
  input  logic                        areset,
  input  logic                        ctrl_start,
  input  logic [`AXI_ADDR_WIDTH-1:0]  ctrl_addr_offset,
  input  logic [`XFER_SIZE_WIDTH-1:0] ctrl_xfer_size_in_bytes,
  output logic                        cmd_load,
  output logic [`AXI_ADDR_WIDTH-1:0]  cmd_addr,
  output axi_read_pkg::rd_len_u       cmd_len
);

  import axi_read_pkg::*;

  // Offset bits inside one burst
  localparam logic [`AXI_ADDR_WIDTH-1:0] ADDR_MASK = `AXI_ADDR_WIDTH'(BURST_BYTES - 1);

  logic                 start_d1;
  logic                 byte_rem;
  logic [LEN_WIDTH-1:0] whole_words;

  // Count bytes beyond the last whole word
  assign byte_rem    = |ctrl_xfer_size_in_bytes[LOG_DW_BYTES-1:0];
  assign whole_words = ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: LEN_WIDTH];

  //////////////////////////////////////////////////
  // Command registers
  //////////////////////////////////////////////////
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up, then store as words minus one
      cmd_len.words <= byte_rem ? whole_words : whole_words - 1'b1;
      cmd_addr      <= ctrl_addr_offset & ~ADDR_MASK;
    end
  end

  // Two stage delay of the start pulse
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      cmd_load <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      cmd_load <= start_d1;
    end
  end

  // A second load right after the first would restart the stages mid setup
  a_single_load: assert property (
    @(posedge aclk) disable iff (areset)
    cmd_load |=> !cmd_load
  );

endmodule

/* verilog/read_return_buffer.sv */
//////////////////////////////////////////////////
// Read data buffer feeding the output stream
// Depth holds every outstanding burst, so rready stays high
// Done may come while data is still buffered
//////////////////////////////////////////////////

`include "axi_read_config.svh"

module read_return_buffer (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       cmd_load,
  input  axi_read_pkg::rd_len_u      cmd_len,
  input  logic                       m_axi_rvalid,
  input  logic [`AXI_DATA_WIDTH-1:0] m_axi_rdata,
  input  logic                       m_axi_rlast,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [`AXI_DATA_WIDTH-1:0] m_axis_tdata,
  output logic                       m_axis_tlast,
  output logic                       burst_retired,
  output logic                       ctrl_done
);

  import axi_read_pkg::*;

  // Entry is the last flag on top of the data word
  logic [`AXI_DATA_WIDTH:0] mem [FIFO_DEPTH];

  // Extra top bit tells full from empty
  logic [FIFO_AWIDTH:0]  wr_ptr;
  logic [FIFO_AWIDTH:0]  rd_ptr;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  wr_en;
  logic                  rd_en;
  logic                  rlast_xfer;
  logic                  r_final;
  logic [XACT_WIDTH-1:0] r_to_go;

  //////////////////////////////////////////////////
  // Buffer
  //////////////////////////////////////////////////
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[FIFO_AWIDTH] != rd_ptr[FIFO_AWIDTH]) &&
                      (wr_ptr[FIFO_AWIDTH-1:0] == rd_ptr[FIFO_AWIDTH-1:0]);

  // Every beat on the read channel is taken
  assign wr_en = m_axi_rvalid;
  assign rd_en = m_axis_tvalid & m_axis_tready;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_AWIDTH-1:0]] <= {m_axi_rlast, m_axi_rdata};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Head entry shows without a read request
  assign m_axis_tvalid = !fifo_empty;
  assign {m_axis_tlast, m_axis_tdata} = mem[rd_ptr[FIFO_AWIDTH-1:0]];

  // One slot back to the issue stage per drained burst
  assign burst_retired = rd_en & m_axis_tlast;

  //////////////////////////////////////////////////
  // Completion
  //////////////////////////////////////////////////
  assign rlast_xfer = m_axi_rvalid & m_axi_rlast;
  assign r_final    = (r_to_go == '0);

  // Bursts still to return after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      r_to_go <= '0;
    end else if (cmd_load) begin
      r_to_go <= cmd_len.fields.bursts;
    end else if (rlast_xfer && !r_final) begin
      r_to_go <= r_to_go - 1'b1;
    end
  end

  // Single pulse on the final rlast
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= rlast_xfer & r_final;
    end
  end

  // Relies on the outstanding limit in the issue stage
  a_no_overflow: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_rvalid |-> !fifo_full
  );

endmodule
